// ==== compile.f ====
mpu_bus_pkg.sv
mpu_irq_pkg.sv
mpu_arbiter.sv
mpu_pit.sv
mpu_pic.sv
mpu_top.sv
tb_mpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mpu -f compile.f -o tb_mpu
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/tb_mpu
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0

// ==== tb_mpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mpu
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;
();

localparam int CH = 4;
localparam int N_RAND = 300;
// four timer transfers plus three for each of twelve interrupt rounds
localparam int N_DIR = 40;
// cycle budget for the whole run
localparam int LIMIT = 20 * (N_RAND + N_DIR);
localparam int RELOAD_N = 5;

logic clk;
logic reset;
logic [CH-1:0] req_valid;
bus_op_e [CH-1:0] req_op;
logic [CH-1:0][BUS_AW-1:0] req_adr;
logic [CH-1:0][BUS_DW-1:0] req_dat;
logic [CH-1:0] req_ready;
logic [CH-1:0] rsp_valid;
logic [BUS_DW-1:0] rsp_dat;
logic mem_req_valid;
logic mem_req_ready;
bus_op_e mem_op;
logic [BUS_AW-1:0] mem_adr;
logic [BUS_DW-1:0] mem_dat;
logic mem_rsp_valid;
logic [BUS_DW-1:0] mem_rsp_dat;
logic [IRQ_N-1:0] irq_bus;
logic [PIT_N-1:0] gate;
logic [PIT_N-1:0] pit_out;
logic irq;
logic [4:0] cause;

mpu_top #(
	.CHANNELS(CH)
) dut (
	.clk_i(clk),
	.reset_i(reset),
	.req_valid_i(req_valid),
	.req_op_i(req_op),
	.req_adr_i(req_adr),
	.req_dat_i(req_dat),
	.req_ready_o(req_ready),
	.rsp_valid_o(rsp_valid),
	.rsp_dat_o(rsp_dat),
	.mem_req_valid_o(mem_req_valid),
	.mem_req_ready_i(mem_req_ready),
	.mem_op_o(mem_op),
	.mem_adr_o(mem_adr),
	.mem_dat_o(mem_dat),
	.mem_rsp_valid_i(mem_rsp_valid),
	.mem_rsp_dat_i(mem_rsp_dat),
	.irq_bus_i(irq_bus),
	.gate_i(gate),
	.pit_out_o(pit_out),
	.irq_o(irq),
	.cause_o(cause)
);

// ==========================================================
// testbench state and reference model
// ==========================================================

logic [31:0] seed = 32'h9f993332;
int cyc = 0;
int issued = 0;
int completed = 0;
bit rand_mode = 0;
bit irq_mode = 0;
logic [PIT_N-1:0] gate_drv = '1;
// timers whose pulses are expected
logic [PIT_N-1:0] pit_watch = '0;
int last_pulse = -1;
int pulses = 0;

// per-channel request waiting for its handshake
bit ch_pend [CH];
bus_op_e ch_op [CH];
logic [31:0] ch_adr [CH];
logic [31:0] ch_dat [CH];
logic [31:0] ch_rdat [CH];
int ch_done [CH];

// arbiter model, one transaction in flight
int ptr_m = 0;
bit busy = 0;
int own = 0;
bit own_mem = 0;
bit mem_taken = 0;
bit exp_valid = 0;
int exp_cyc = 0;
int acc_cyc = 0;
bit chk_data = 0;
logic [31:0] exp_data;
bus_op_e t_op;
logic [31:0] t_adr;
logic [31:0] t_dat;

// register copies of the timers and the interrupt controller
logic [31:0] reload_m [PIT_N];
logic [2:0] ctrl_m [PIT_N];
logic [31:0] en_m = '0;
logic [31:0] pend_m = '0;
logic [31:0] src_prev = '0;
logic irq_m = 0;

// memory behind the external port
logic [31:0] mem_m [64];
int mem_wait = 0;
logic [31:0] mem_rdat_q;

initial
begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

function automatic logic [31:0] next_rand();
	seed = seed ^ (seed << 13);
	seed = seed ^ (seed >> 17);
	seed = seed ^ (seed << 5);
	return seed;
endfunction

// first requesting channel at or after the pointer
function automatic int winner(input logic [CH-1:0] v);
	int j;
	for (int i = 0; i < CH; i++)
	begin
		j = (ptr_m + i) % CH;
		if (v[j])
			return j;
	end
	return -1;
endfunction

// highest pending-and-enabled source, 0 when none
function automatic int top_src(input logic [31:0] v);
	int r;
	r = 0;
	for (int i = 1; i < 32; i++)
		if (v[i])
			r = i;
	return r;
endfunction

function automatic bit is_io(input logic [31:0] a);
	return a[31:24] == IO_PAGE && (a[15:12] == IO_SEL_PIT || a[15:12] == IO_SEL_PIC);
endfunction

function automatic logic [31:0] pit_adr(input int tm, input pit_reg_e rg);
	return {IO_PAGE, 8'h00, IO_SEL_PIT, 12'h000} | 32'(tm << 4) | (32'(rg) << 2);
endfunction

function automatic logic [31:0] pic_adr(input pic_reg_e rg);
	return {IO_PAGE, 8'h00, IO_SEL_PIC, 12'h000} | (32'(rg) << 2);
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		$display("MISMATCH %s got %h expected %h", name, got, exp);
		$display("SOME TESTS FAILED");
		$fatal(1, "value check failed");
	end
endtask

// random request for one channel, memory most of the time
task automatic new_request(input int c);
	logic [31:0] r;
	logic [31:0] d;
	r = next_rand();
	d = next_rand();
	ch_op[c] = r[3] ? BUS_WRITE : BUS_READ;
	if (r[2:0] < 3'd5)
		ch_adr[c] = 32'h0001_0000 | {24'h0, r[9:4], 2'b00};
	else if (r[2:0] < 3'd7)
	begin
		ch_adr[c] = pit_adr(int'(r[11:10]), pit_reg_e'(r[13:12]));
		// timers stay stopped here
		if (r[13:12] == 2'd2)
			d = d & 32'h6;
	end
	else
		ch_adr[c] = pic_adr(pic_reg_e'(r[13:12]));
	ch_dat[c] = d;
	ch_pend[c] = 1'b1;
	issued++;
endtask

// ==========================================================
// per-cycle drive and sample
// ==========================================================

task automatic drive_inputs();
	logic [31:0] r;
	@(posedge clk);
	#1;
	for (int c = 0; c < CH; c++)
	begin
		r = next_rand();
		if (rand_mode && !ch_pend[c] && issued < N_RAND && r[0])
			new_request(c);
		req_valid[c] = ch_pend[c];
		req_op[c] = ch_op[c];
		req_adr[c] = ch_adr[c];
		req_dat[c] = ch_dat[c];
	end
	r = next_rand();
	mem_req_ready = r[0];
	mem_rsp_valid = 1'b0;
	if (mem_wait > 0)
	begin
		mem_wait--;
		if (mem_wait == 0)
		begin
			mem_rsp_valid = 1'b1;
			mem_rsp_dat = mem_rdat_q;
		end
	end
	// sparse pulses, about one source in sixteen per cycle
	irq_bus = irq_mode ? (next_rand() & next_rand() & next_rand() & next_rand()) : '0;
	gate = gate_drv;
endtask

task automatic sample_and_check();
	logic [31:0] src;
	logic [31:0] pe;
	logic [31:0] ack_mask;
	logic [CH-1:0] exp_ready;
	logic [CH-1:0] exp_rsp;
	logic [1:0] rg;
	int w;
	int cause_now;
	int tm;
	int idx;
	cyc++;
	if (cyc > LIMIT)
	begin
		$display("timeout after %0d cycles, transactions did not finish", cyc);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation timeout");
	end
	// controller outputs against the model
	pe = pend_m & en_m;
	cause_now = top_src(pe);
	check("irq_o", 32'(irq), 32'(irq_m));
	check("cause_o", 32'(cause), 32'(cause_now));
	check("pit_out_o", 32'(pit_out & ~pit_watch), 32'h0);
	if (pit_out[1] && pit_watch[1])
	begin
		if (last_pulse >= 0)
			check("pit_out_o period", 32'(cyc - last_pulse), 32'(RELOAD_N + 1));
		last_pulse = cyc;
		pulses++;
	end
	// sources as the controller sees them this cycle
	src = irq_bus;
	for (int n = 0; n < PIT_N; n++)
		if (pit_out[n] && ctrl_m[n][2])
			src[PIT_IRQ_BASE + n] = 1'b1;
	// grant follows the pointer rule
	exp_ready = '0;
	w = winner(req_valid);
	if (!busy && w >= 0)
		exp_ready[w] = 1'b1;
	check("req_ready_o", 32'(req_ready), 32'(exp_ready));
	exp_rsp = '0;
	if (busy && exp_valid && cyc == exp_cyc)
		exp_rsp[own] = 1'b1;
	check("rsp_valid_o", 32'(rsp_valid), 32'(exp_rsp));
	if (exp_rsp != '0)
	begin
		if (chk_data)
			check("rsp_dat_o", rsp_dat, exp_data);
		ch_rdat[own] = rsp_dat;
		ch_done[own]++;
		completed++;
		busy = 0;
		ptr_m = (own + 1) % CH;
	end
	// memory port carries the owner's request
	check("mem_req_valid_o", 32'(mem_req_valid), 32'(busy && own_mem && !mem_taken));
	if (mem_req_valid && mem_req_ready)
	begin
		check("mem_op_o", 32'(mem_op), 32'(t_op));
		check("mem_adr_o", mem_adr, t_adr);
		check("mem_dat_o", mem_dat, t_dat);
		idx = int'(t_adr[7:2]);
		mem_taken = 1;
		if (t_op == BUS_WRITE)
		begin
			mem_m[idx] = t_dat;
			mem_rdat_q = '0;
			chk_data = 0;
		end
		else
		begin
			mem_rdat_q = mem_m[idx];
			exp_data = mem_m[idx];
			chk_data = 1;
		end
		mem_wait = 1 + int'(next_rand() & 32'h3);
	end
	if (mem_rsp_valid && busy && own_mem)
	begin
		exp_valid = 1;
		exp_cyc = cyc + 1;
	end
	// register access lands one cycle after the handshake
	ack_mask = '0;
	if (busy && !own_mem && cyc == acc_cyc)
	begin
		rg = t_adr[3:2];
		tm = int'(t_adr[5:4]);
		chk_data = (t_op == BUS_READ);
		exp_data = '0;
		if (t_adr[15:12] == IO_SEL_PIT)
		begin
			if (t_op == BUS_WRITE)
			begin
				if (pit_reg_e'(rg) == PIT_RELOAD)
					reload_m[tm] = t_dat;
				else if (pit_reg_e'(rg) == PIT_CTRL)
					ctrl_m[tm] = t_dat[2:0];
			end
			else
				case (pit_reg_e'(rg))
				PIT_RELOAD: exp_data = reload_m[tm];
				PIT_COUNT:
					begin
						// a stopped timer still holds its reload
						exp_data = reload_m[tm];
						chk_data = !ctrl_m[tm][0];
					end
				PIT_CTRL: exp_data = {29'h0, ctrl_m[tm]};
				default: exp_data = '0;
				endcase
		end
		else
		begin
			if (t_op == BUS_WRITE)
			begin
				if (pic_reg_e'(rg) == PIC_ENABLE)
					en_m = t_dat;
			end
			else
				case (pic_reg_e'(rg))
				PIC_ENABLE: exp_data = en_m;
				PIC_PENDING: exp_data = pend_m;
				PIC_CAUSE:
					begin
						exp_data = 32'(cause_now);
						ack_mask[cause_now] = 1'b1;
					end
				default: exp_data = '0;
				endcase
		end
	end
	// next controller state, edges on source 0 never count
	pend_m = (pend_m & ~ack_mask) | (src & ~src_prev & 32'hFFFF_FFFE);
	irq_m = |pe;
	src_prev = src;
	// handshake opens the next transaction
	if ((req_valid & req_ready) != '0)
	begin
		own = w;
		busy = 1;
		t_op = ch_op[w];
		t_adr = ch_adr[w];
		t_dat = ch_dat[w];
		ch_pend[w] = 0;
		own_mem = !is_io(t_adr);
		mem_taken = 0;
		exp_valid = !own_mem;
		exp_cyc = cyc + 3;
		acc_cyc = cyc + 1;
		chk_data = 0;
	end
endtask

task automatic step();
	drive_inputs();
	@(negedge clk);
	sample_and_check();
endtask

// one transfer on channel 0, waits for its response
task automatic io_xfer(input bus_op_e op, input logic [31:0] adr, input logic [31:0] dat,
	output logic [31:0] rdat);
	int d0;
	d0 = ch_done[0];
	ch_op[0] = op;
	ch_adr[0] = adr;
	ch_dat[0] = dat;
	ch_pend[0] = 1'b1;
	while (ch_done[0] == d0)
		step();
	rdat = ch_rdat[0];
endtask

// ==========================================================
// test sequence
// ==========================================================

initial
begin
	logic [31:0] rd;
	logic [31:0] c1;
	logic [31:0] c2;
	reset = 1'b1;
	req_valid = '0;
	req_op = '0;
	req_adr = '0;
	req_dat = '0;
	mem_req_ready = 1'b0;
	mem_rsp_valid = 1'b0;
	mem_rsp_dat = '0;
	irq_bus = '0;
	gate = '1;
	for (int c = 0; c < CH; c++)
	begin
		ch_pend[c] = 0;
		ch_op[c] = BUS_READ;
		ch_adr[c] = '0;
		ch_dat[c] = '0;
		ch_done[c] = 0;
	end
	for (int n = 0; n < PIT_N; n++)
	begin
		reload_m[n] = '0;
		ctrl_m[n] = '0;
	end
	// fill value follows the full byte address
	for (int i = 0; i < 64; i++)
		mem_m[i] = (32'h0001_0000 | 32'(i << 2)) ^ 32'h5A3C_96E1;
	repeat (2) @(posedge clk);
	#1;
	reset = 1'b0;

	// mixed memory and register traffic from every channel
	rand_mode = 1;
	while (completed < N_RAND)
		step();
	rand_mode = 0;

	// timer 1 periodic with interrupts
	pit_watch = 4'b0010;
	io_xfer(BUS_WRITE, pit_adr(1, PIT_RELOAD), RELOAD_N, rd);
	io_xfer(BUS_WRITE, pit_adr(1, PIT_CTRL), 32'h7, rd);
	while (pulses < 5)
		step();
	// gate low must hold the count
	gate_drv = 4'b1101;
	last_pulse = -1;
	repeat (2) step();
	io_xfer(BUS_READ, pit_adr(1, PIT_COUNT), '0, c1);
	io_xfer(BUS_READ, pit_adr(1, PIT_COUNT), '0, c2);
	check("PIT_COUNT frozen", c2, c1);
	if (c1 > RELOAD_N)
	begin
		$display("frozen count %0d is above the reload value", c1);
		$display("SOME TESTS FAILED");
		$fatal(1, "count out of range");
	end
	gate_drv = 4'b1111;

	// random interrupt pulses with changing enable masks
	irq_mode = 1;
	for (int k = 0; k < 12; k++)
	begin
		io_xfer(BUS_WRITE, pic_adr(PIC_ENABLE), next_rand(), rd);
		repeat (4) step();
		io_xfer(BUS_READ, pic_adr(PIC_CAUSE), '0, rd);
		io_xfer(BUS_READ, pic_adr(PIC_PENDING), '0, rd);
	end
	irq_mode = 0;
	repeat (4) step();

	$display("ALL TESTS PASSED");
	$finish;
end

endmodule

`default_nettype wire

// ==== mpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mpu_top
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;
#(
	parameter int CHANNELS = 4
)
(
	input wire logic clk_i,
	input wire logic reset_i,
	// requester channels
	input wire logic [CHANNELS-1:0] req_valid_i,
	input wire bus_op_e [CHANNELS-1:0] req_op_i,
	input wire logic [CHANNELS-1:0][BUS_AW-1:0] req_adr_i,
	input wire logic [CHANNELS-1:0][BUS_DW-1:0] req_dat_i,
	output logic [CHANNELS-1:0] req_ready_o,
	output logic [CHANNELS-1:0] rsp_valid_o,
	output logic [BUS_DW-1:0] rsp_dat_o,
	// external memory
	output logic mem_req_valid_o,
	input wire logic mem_req_ready_i,
	output bus_op_e mem_op_o,
	output logic [BUS_AW-1:0] mem_adr_o,
	output logic [BUS_DW-1:0] mem_dat_o,
	input wire logic mem_rsp_valid_i,
	input wire logic [BUS_DW-1:0] mem_rsp_dat_i,
	// interrupts and timers
	input wire logic [IRQ_N-1:0] irq_bus_i,
	input wire logic [PIT_N-1:0] gate_i,
	output logic [PIT_N-1:0] pit_out_o,
	output logic irq_o,
	output logic [$clog2(IRQ_N)-1:0] cause_o
);

logic bus_valid;
bus_op_e bus_op;
logic [BUS_AW-1:0] bus_adr;
logic [BUS_DW-1:0] bus_dat;
logic bus_ack;
logic [BUS_DW-1:0] bus_rdat;
logic io_page;
logic pit_sel;
logic pic_sel;
logic mem_sel;
logic mem_issued_q;
logic pit_ack;
logic pic_ack;
logic [BUS_DW-1:0] pit_rdat;
logic [BUS_DW-1:0] pic_rdat;
logic [PIT_N-1:0] pit_irq;
logic [IRQ_N-1:0] iirq;

mpu_arbiter #(
	.CHANNELS(CHANNELS)
) u_arb (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.req_valid_i(req_valid_i),
	.req_op_i(req_op_i),
	.req_adr_i(req_adr_i),
	.req_dat_i(req_dat_i),
	.req_ready_o(req_ready_o),
	.rsp_valid_o(rsp_valid_o),
	.rsp_dat_o(rsp_dat_o),
	.bus_valid_o(bus_valid),
	.bus_op_o(bus_op),
	.bus_adr_o(bus_adr),
	.bus_dat_o(bus_dat),
	.bus_ack_i(bus_ack),
	.bus_rdat_i(bus_rdat)
);

// ==========================================================
// address decode
// ==========================================================

assign io_page = (bus_adr[31:24] == IO_PAGE);
assign pit_sel = io_page && (bus_adr[15:12] == IO_SEL_PIT);
assign pic_sel = io_page && (bus_adr[15:12] == IO_SEL_PIC);
// unclaimed I/O addresses fall through to memory as well
assign mem_sel = ~pit_sel & ~pic_sel;

mpu_pit u_pit (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.sel_i(pit_sel),
	.valid_i(bus_valid),
	.op_i(bus_op),
	.adr_i(bus_adr),
	.dat_i(bus_dat),
	.ack_o(pit_ack),
	.rdat_o(pit_rdat),
	.gate_i(gate_i),
	.out_o(pit_out_o),
	.irq_o(pit_irq)
);

mpu_pic u_pic (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.sel_i(pic_sel),
	.valid_i(bus_valid),
	.op_i(bus_op),
	.adr_i(bus_adr),
	.dat_i(bus_dat),
	.ack_o(pic_ack),
	.rdat_o(pic_rdat),
	.irq_src_i(iirq),
	.irq_o(irq_o),
	.cause_o(cause_o)
);

// ==========================================================
// memory port
// ==========================================================

// request side drops once memory has taken it
always_ff @(posedge clk_i)
	if (reset_i)
		mem_issued_q <= 1'b0;
	else if (bus_ack)
		mem_issued_q <= 1'b0;
	else if (mem_req_valid_o && mem_req_ready_i)
		mem_issued_q <= 1'b1;

assign mem_req_valid_o = bus_valid & mem_sel & ~mem_issued_q;
assign mem_op_o = bus_op;
assign mem_adr_o = bus_adr;
assign mem_dat_o = bus_dat;

// response from whichever target owns the cycle
assign bus_ack = pit_ack | pic_ack | (bus_valid & mem_sel & mem_rsp_valid_i);

always_comb
	if (pic_ack)
		bus_rdat = pic_rdat;
	else if (pit_ack)
		bus_rdat = pit_rdat;
	else
		bus_rdat = mem_rsp_dat_i;

// timer interrupts sit at the top of the source range
always_comb
begin
	iirq = irq_bus_i;
	iirq[PIT_IRQ_BASE +: PIT_N] = irq_bus_i[PIT_IRQ_BASE +: PIT_N] | pit_irq;
end

// a stalled memory request keeps its address until taken
a_mem_hold: assert property (@(posedge clk_i) disable iff (reset_i)
	mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_adr_o));

endmodule

`default_nettype wire

// ==== mpu_pic.sv ====
`timescale 1ns/10ps
`default_nettype none

module mpu_pic
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;
(
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic sel_i,
	input wire logic valid_i,
	input wire bus_op_e op_i,
	input wire logic [BUS_AW-1:0] adr_i,
	input wire logic [BUS_DW-1:0] dat_i,
	output logic ack_o,
	output logic [BUS_DW-1:0] rdat_o,
	input wire logic [IRQ_N-1:0] irq_src_i,
	output logic irq_o,
	output logic [$clog2(IRQ_N)-1:0] cause_o
);

localparam int CW = $clog2(IRQ_N);

logic [IRQ_N-1:0] src_q;
logic [IRQ_N-1:0] enable_q;
logic [IRQ_N-1:0] pending_q;
logic [IRQ_N-1:0] rise;
logic [IRQ_N-1:0] pend_en;
logic [IRQ_N-1:0] ack_clr;
pic_reg_e reg_sel;
logic access;

assign reg_sel = pic_reg_e'(adr_i[3:2]);
assign access = sel_i & valid_i & ~ack_o;

// ==========================================================
// edge capture and priority
// ==========================================================

// rising edges only, source 0 never latches
assign rise = irq_src_i & ~src_q & {{(IRQ_N - 1){1'b1}}, 1'b0};

assign pend_en = pending_q & enable_q;

// highest numbered source wins
always_comb
begin
	cause_o = '0;
	for (int i = 1; i < IRQ_N; i++)
		if (pend_en[i])
			cause_o = CW'(i);
end

// reading the cause register acknowledges that source
always_comb
begin
	ack_clr = '0;
	if (access && op_i == BUS_READ && reg_sel == PIC_CAUSE)
		ack_clr[cause_o] = 1'b1;
end

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		src_q <= '0;
		enable_q <= '0;
		pending_q <= '0;
		irq_o <= 1'b0;
		ack_o <= 1'b0;
	end
	else
	begin
		src_q <= irq_src_i;
		// a new edge on the acknowledged source keeps it pending
		pending_q <= (pending_q & ~ack_clr) | rise;
		irq_o <= |pend_en;
		ack_o <= access;
		// pending and cause ignore writes
		if (access && op_i == BUS_WRITE && reg_sel == PIC_ENABLE)
			enable_q <= dat_i[IRQ_N-1:0];
	end
end

// ==========================================================
// register read
// ==========================================================

always_ff @(posedge clk_i)
	if (access)
		case (reg_sel)
		PIC_ENABLE:  rdat_o <= BUS_DW'(enable_q);
		PIC_PENDING: rdat_o <= BUS_DW'(pending_q);
		PIC_CAUSE:   rdat_o <= BUS_DW'(cause_o);
		default:     rdat_o <= '0;
		endcase

endmodule

`default_nettype wire

// ==== mpu_pit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mpu_pit
	import mpu_bus_pkg::*;
	import mpu_irq_pkg::*;
(
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic sel_i,
	input wire logic valid_i,
	input wire bus_op_e op_i,
	input wire logic [BUS_AW-1:0] adr_i,
	input wire logic [BUS_DW-1:0] dat_i,
	output logic ack_o,
	output logic [BUS_DW-1:0] rdat_o,
	input wire logic [PIT_N-1:0] gate_i,
	output logic [PIT_N-1:0] out_o,
	output logic [PIT_N-1:0] irq_o
);

localparam int TW = $clog2(PIT_N);

// per-timer state
logic [BUS_DW-1:0] reload_q [PIT_N];
logic [BUS_DW-1:0] count_q [PIT_N];
// ctrl bit 0 enable, bit 1 auto-reload, bit 2 interrupt enable
logic [2:0] ctrl_q [PIT_N];

logic [TW-1:0] tmr_sel;
pit_reg_e reg_sel;
logic access;

// bits 5:4 pick the timer, bits 3:2 the register
assign tmr_sel = adr_i[4 +: TW];
assign reg_sel = pit_reg_e'(adr_i[3:2]);

// first cycle of a bus cycle aimed here
assign access = sel_i & valid_i & ~ack_o;

// ==========================================================
// bus slave
// ==========================================================

always_ff @(posedge clk_i)
	if (reset_i)
		ack_o <= 1'b0;
	else
		ack_o <= access;

always_ff @(posedge clk_i)
	if (access)
		case (reg_sel)
		PIT_RELOAD: rdat_o <= reload_q[tmr_sel];
		PIT_COUNT:  rdat_o <= count_q[tmr_sel];
		PIT_CTRL:   rdat_o <= {{(BUS_DW - 3){1'b0}}, ctrl_q[tmr_sel]};
		default:    rdat_o <= '0;
		endcase

// ==========================================================
// counters
// ==========================================================

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		for (int n = 0; n < PIT_N; n++)
		begin
			reload_q[n] <= '0;
			count_q[n] <= '0;
			ctrl_q[n] <= '0;
		end
		out_o <= '0;
		irq_o <= '0;
	end
	else
	begin
		for (int n = 0; n < PIT_N; n++)
		begin
			out_o[n] <= 1'b0;
			irq_o[n] <= 1'b0;
			// gate low freezes the count
			if (ctrl_q[n][0] && gate_i[n])
			begin
				if (count_q[n] == '0)
				begin
					out_o[n] <= 1'b1;
					irq_o[n] <= ctrl_q[n][2];
					// periodic mode reloads, one-shot stops
					if (ctrl_q[n][1])
						count_q[n] <= reload_q[n];
					else
						ctrl_q[n][0] <= 1'b0;
				end
				else
					count_q[n] <= count_q[n] - 1'b1;
			end
		end
		// a bus write takes priority over the counter in the same cycle
		if (access && op_i == BUS_WRITE)
			case (reg_sel)
			PIT_RELOAD:
				begin
					reload_q[tmr_sel] <= dat_i;
					count_q[tmr_sel] <= dat_i;
				end
			PIT_CTRL:
				ctrl_q[tmr_sel] <= dat_i[2:0];
			// count is read-only
			default: ;
			endcase
	end
end

// the bus cycle is still presented when the answer goes back
a_ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
	ack_o |-> sel_i && valid_i);

endmodule

`default_nettype wire

// ==== mpu_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mpu_arbiter
	import mpu_bus_pkg::*;
#(
	parameter int CHANNELS = 4
)
(
	input wire logic clk_i,
	input wire logic reset_i,
	// requester side, one slot per channel
	input wire logic [CHANNELS-1:0] req_valid_i,
	input wire bus_op_e [CHANNELS-1:0] req_op_i,
	input wire logic [CHANNELS-1:0][BUS_AW-1:0] req_adr_i,
	input wire logic [CHANNELS-1:0][BUS_DW-1:0] req_dat_i,
	output logic [CHANNELS-1:0] req_ready_o,
	output logic [CHANNELS-1:0] rsp_valid_o,
	output logic [BUS_DW-1:0] rsp_dat_o,
	// shared bus side
	output logic bus_valid_o,
	output bus_op_e bus_op_o,
	output logic [BUS_AW-1:0] bus_adr_o,
	output logic [BUS_DW-1:0] bus_dat_o,
	input wire logic bus_ack_i,
	input wire logic [BUS_DW-1:0] bus_rdat_i
);

localparam int CW = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

typedef enum logic [1:0] {
	ARB_IDLE,
	ARB_BUS,
	ARB_RESP
} arb_state_e;

arb_state_e state_q;
logic [CW-1:0] ptr_q;
logic [CW-1:0] own_q;
logic [CW-1:0] win_idx;
logic win_found;
bus_op_e op_q;
logic [BUS_AW-1:0] adr_q;
logic [BUS_DW-1:0] dat_q;
logic [BUS_DW-1:0] rdat_q;

// ==========================================================
// round-robin pick
// ==========================================================

// first valid channel at or after the pointer, wrapping around
always_comb
begin
	int j;
	win_found = 1'b0;
	win_idx = ptr_q;
	for (int i = 0; i < CHANNELS; i++)
	begin
		j = int'(ptr_q) + i;
		if (j >= CHANNELS)
			j = j - CHANNELS;
		if (!win_found && req_valid_i[j])
		begin
			win_found = 1'b1;
			win_idx = CW'(j);
		end
	end
end

// only the winner sees ready, everyone else stays stalled
always_comb
begin
	req_ready_o = '0;
	if (state_q == ARB_IDLE && win_found)
		req_ready_o[win_idx] = 1'b1;
end

// ==========================================================
// bus ownership
// ==========================================================

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		state_q <= ARB_IDLE;
		ptr_q <= '0;
		own_q <= '0;
	end
	else
	begin
		case (state_q)
		ARB_IDLE:
			if (win_found)
			begin
				state_q <= ARB_BUS;
				own_q <= win_idx;
			end
		ARB_BUS:
			// hold the cycle until the target answers
			if (bus_ack_i)
				state_q <= ARB_RESP;
		ARB_RESP:
			begin
				state_q <= ARB_IDLE;
				// next round starts just past the channel served
				ptr_q <= (own_q == CW'(CHANNELS - 1)) ? '0 : own_q + 1'b1;
			end
		default:
			state_q <= ARB_IDLE;
		endcase
	end
end

// request payload, captured at the handshake
always_ff @(posedge clk_i)
	if (state_q == ARB_IDLE && win_found)
	begin
		op_q <= req_op_i[win_idx];
		adr_q <= req_adr_i[win_idx];
		dat_q <= req_dat_i[win_idx];
	end

// read data captured with the ack
always_ff @(posedge clk_i)
	if (state_q == ARB_BUS && bus_ack_i)
		rdat_q <= bus_rdat_i;

assign bus_valid_o = (state_q == ARB_BUS);
assign bus_op_o = op_q;
assign bus_adr_o = adr_q;
assign bus_dat_o = dat_q;

// one-cycle response pulse to the owner only
always_comb
begin
	rsp_valid_o = '0;
	if (state_q == ARB_RESP)
		rsp_valid_o[own_q] = 1'b1;
end

assign rsp_dat_o = rdat_q;

// a target answers only inside a bus cycle
a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
	bus_ack_i |-> bus_valid_o);

// a channel that is not taken keeps its request on the port
for (genvar c = 0; c < CHANNELS; c++)
begin : g_req_hold
	a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		req_valid_i[c] && !req_ready_o[c] |=> req_valid_i[c] && $stable(req_adr_i[c]));
end

endmodule

`default_nettype wire

// ==== mpu_irq_pkg.sv ====
`default_nettype none

package mpu_irq_pkg;

	// interrupt sources seen by the controller, source 0 is "none"
	localparam int IRQ_N = 32;

	// interval timers, timer n drives source PIT_IRQ_BASE+n
	localparam int PIT_N = 4;
	localparam int PIT_IRQ_BASE = 28;

	// timer register index, address bits 3:2
	typedef enum logic [1:0] {
		PIT_RELOAD = 2'd0,
		PIT_COUNT  = 2'd1,
		PIT_CTRL   = 2'd2
	} pit_reg_e;

	// interrupt controller register index, address bits 3:2
	typedef enum logic [1:0] {
		PIC_ENABLE  = 2'd0,
		PIC_PENDING = 2'd1,
		PIC_CAUSE   = 2'd2
	} pic_reg_e;

endpackage

`default_nettype wire

// ==== mpu_bus_pkg.sv ====
`default_nettype none

// ==========================================================
// shared bus definitions
// one 32-bit bus from the arbiter to every target
// ==========================================================

package mpu_bus_pkg;

	// address and data widths of the bus and of every channel
	localparam int BUS_AW = 32;
	localparam int BUS_DW = 32;

	// transfer direction, carried with every request
	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_op_e;

	// top address byte of the I/O page
	localparam logic [7:0] IO_PAGE = 8'hFE;

	// device select inside the I/O page, address bits 15:12
	localparam logic [3:0] IO_SEL_PIT = 4'h0;
	localparam logic [3:0] IO_SEL_PIC = 4'h1;

endpackage

`default_nettype wire
